/* lu_defs.svh */
`ifndef LU_DEFS_SVH
`define LU_DEFS_SVH

// matrix dimension
`define LU_N 4

// bits per real or imaginary component
`define LU_DW 16

// fraction bits of the fixed point format
`define LU_FRAC 10

// row address width, enough for LU_N rows
`define LU_AW 2

`endif

/* cplx_pkg.sv */
`default_nettype none

`include "lu_defs.svh"

package cplx_pkg;

  typedef logic signed [`LU_DW-1:0]   comp_t;
  typedef logic        [2*`LU_DW-1:0] cplx_t;  // {im, re}
  typedef logic signed [4*`LU_DW-1:0] wide_t;

  // full product, then shift out the fraction bits
  function automatic cplx_t cplx_mul(cplx_t a, cplx_t b);
    comp_t ar, ai, br, bi;
    wide_t p_re, p_im;
    ar = a[`LU_DW-1:0];
    ai = a[2*`LU_DW-1:`LU_DW];
    br = b[`LU_DW-1:0];
    bi = b[2*`LU_DW-1:`LU_DW];
    p_re = (wide_t'(ar) * wide_t'(br) - wide_t'(ai) * wide_t'(bi)) >>> `LU_FRAC;
    p_im = (wide_t'(ar) * wide_t'(bi) + wide_t'(ai) * wide_t'(br)) >>> `LU_FRAC;
    return {p_im[`LU_DW-1:0], p_re[`LU_DW-1:0]};  // wraps to component width
  endfunction

  function automatic cplx_t cplx_sub(cplx_t a, cplx_t b);
    comp_t d_re, d_im;
    d_re = comp_t'(a[`LU_DW-1:0] - b[`LU_DW-1:0]);
    d_im = comp_t'(a[2*`LU_DW-1:`LU_DW] - b[2*`LU_DW-1:`LU_DW]);
    return {d_im, d_re};
  endfunction

endpackage

`default_nettype wire

/* lu_pkg.sv */
`default_nettype none

`include "lu_defs.svh"

package lu_pkg;

  typedef logic [2*`LU_DW*`LU_N-1:0] row_t;  // element j at bits j*2*LU_DW
  typedef logic [`LU_AW-1:0]         row_addr_t;

  typedef enum logic [2:0] {
    IDLE,
    PIVOT,
    RECIP,
    UPDATE,
    EMIT,
    DONE
  } lu_state_t;

endpackage

`default_nettype wire

/* cplx_recip.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module cplx_recip (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            in_valid_i,
  output logic                 in_ready_o,
  input  wire cplx_pkg::cplx_t pivot_i,
  output logic                 out_valid_o,
  input  wire logic            out_ready_i,
  output cplx_pkg::cplx_t      recip_o
);
  localparam int NW = `LU_DW + 2 * `LU_FRAC;  // numerator width
  localparam int CW = $clog2(NW);
  localparam logic [CW-1:0] LAST_STEP = CW'(NW - 1);

  typedef enum logic [2:0] {R_IDLE, R_SQ, R_SUM, R_DIV, R_OUT} rstate_t;

  rstate_t           state;
  logic [CW-1:0]     cnt;
  logic              part;  // 0 real, 1 imag
  cplx_pkg::comp_t   p_re, p_im, re_q, q_signed;
  cplx_pkg::wide_t   sq_re, sq_im, mag, rem, rem_sh, rem_sub;
  logic [NW-1:0]     quo, q_nxt;
  logic              neg, fits;

  function automatic logic [`LU_DW-1:0] abs_c(cplx_pkg::comp_t v);
    return v[`LU_DW-1] ? -v : v;
  endfunction

  // one restoring step, numerator bits shift out of quo
  assign rem_sh   = {rem[4*`LU_DW-2:0], quo[NW-1]};
  assign rem_sub  = rem_sh - mag;
  assign fits     = rem_sh >= mag;
  assign q_nxt    = {quo[NW-2:0], fits};
  assign q_signed = neg ? -cplx_pkg::comp_t'(q_nxt[`LU_DW-1:0])
                        : cplx_pkg::comp_t'(q_nxt[`LU_DW-1:0]);

  assign in_ready_o  = state == R_IDLE;
  assign out_valid_o = state == R_OUT;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state <= R_IDLE;
      cnt   <= '0;
      part  <= 1'b0;
    end else begin
      case (state)
        R_IDLE: if (in_valid_i) state <= R_SQ;
        R_SQ:   state <= R_SUM;
        R_SUM: begin
          cnt  <= '0;
          part <= 1'b0;
          state <= R_DIV;
        end
        R_DIV: begin
          cnt <= cnt + 1'b1;
          if (cnt == LAST_STEP) begin
            cnt  <= '0;
            part <= 1'b1;
            if (part) state <= R_OUT;
          end
        end
        R_OUT:  if (out_ready_i) state <= R_IDLE;
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state)
      R_IDLE: begin
        p_re <= pivot_i[`LU_DW-1:0];
        p_im <= pivot_i[2*`LU_DW-1:`LU_DW];
      end
      R_SQ: begin
        sq_re <= cplx_pkg::wide_t'(p_re) * cplx_pkg::wide_t'(p_re);
        sq_im <= cplx_pkg::wide_t'(p_im) * cplx_pkg::wide_t'(p_im);
      end
      R_SUM: begin
        mag <= sq_re + sq_im;  // |p|^2
        rem <= '0;
        quo <= {abs_c(p_re), {2*`LU_FRAC{1'b0}}};
        neg <= p_re[`LU_DW-1];
      end
      R_DIV: begin
        if (cnt != LAST_STEP) begin
          rem <= fits ? rem_sub : rem_sh;
          quo <= q_nxt;
        end else if (!part) begin
          re_q <= q_signed;
          rem  <= '0;
          quo  <= {abs_c(p_im), {2*`LU_FRAC{1'b0}}};
          neg  <= ~p_im[`LU_DW-1];  // conj flips the imag sign
        end else begin
          recip_o <= {q_signed, re_q};
        end
      end
      default: ;
    endcase
  end

  // no new pivot while a result waits to be taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> !in_valid_i);

endmodule

`default_nettype wire

/* lu_row_update.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module lu_row_update (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              in_valid_i,
  output logic                   in_ready_o,
  input  wire lu_pkg::row_t      lower_row_i,
  input  wire lu_pkg::row_t      pivot_row_i,  // zero left of k
  input  wire cplx_pkg::cplx_t   recip_i,
  input  wire lu_pkg::row_addr_t idx_i,
  input  wire lu_pkg::row_addr_t k_i,
  output logic                   out_valid_o,
  input  wire logic              out_ready_i,
  output cplx_pkg::cplx_t        l_o,
  output lu_pkg::row_t           row_o,
  output lu_pkg::row_addr_t      idx_o,
  output lu_pkg::row_addr_t      k_o
);
  localparam int EW = 2 * `LU_DW;

  logic              s1_valid, s2_valid, s1_ready, s2_ready;
  cplx_pkg::cplx_t   s1_l;
  lu_pkg::row_t      s1_lower, s1_pivot, new_row;
  lu_pkg::row_addr_t s1_idx, s1_k;
  logic              piv_left_zero;

  assign s2_ready    = !s2_valid || out_ready_i;
  assign s1_ready    = !s1_valid || s2_ready;
  assign in_ready_o  = s1_ready;
  assign out_valid_o = s2_valid;

  always_comb begin
    for (int j = 0; j < `LU_N; j++) begin
      new_row[j*EW +: EW] = cplx_pkg::cplx_sub(s1_lower[j*EW +: EW],
                                               cplx_pkg::cplx_mul(s1_l, s1_pivot[j*EW +: EW]));
    end
  end

  // lanes left of k pass through only if the pivot row is zero there
  always_comb begin
    piv_left_zero = 1'b1;
    for (int j = 0; j < `LU_N; j++) begin
      if ((j < int'(k_i)) && (pivot_row_i[j*EW +: EW] != '0)) begin
        piv_left_zero = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) s1_valid <= in_valid_i;
      if (s2_ready) s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && s1_ready) begin
      s1_l     <= cplx_pkg::cplx_mul(lower_row_i[k_i*EW +: EW], recip_i);  // multiplier
      s1_lower <= lower_row_i;
      s1_pivot <= pivot_row_i;
      s1_idx   <= idx_i;
      s1_k     <= k_i;
    end
    if (s1_valid && s2_ready) begin
      row_o <= new_row;
      l_o   <= s1_l;
      idx_o <= s1_idx;
      k_o   <= s1_k;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i |-> piv_left_zero);

endmodule

`default_nettype wire

/* lu_row_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module lu_row_mem (
  input  wire logic              clk_i,
  input  wire logic              host_we_i,
  input  wire lu_pkg::row_addr_t host_addr_i,
  input  wire lu_pkg::row_t      host_row_i,
  input  wire logic              rd_en_i,
  input  wire lu_pkg::row_addr_t rd_addr_i,
  output lu_pkg::row_t           rd_row_o,
  input  wire logic              wr_en_i,
  input  wire lu_pkg::row_addr_t wr_addr_i,
  input  wire lu_pkg::row_t      wr_row_i
);
  lu_pkg::row_t mem [`LU_N];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_row_i;  // engine wins
    end else if (host_we_i) begin
      mem[host_addr_i] <= host_row_i;
    end
    if (rd_en_i) begin
      rd_row_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

/* lu_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module lu_engine (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              start_i,
  output logic                   busy_o,
  output logic                   rd_en_o,
  output lu_pkg::row_addr_t      rd_addr_o,
  input  wire lu_pkg::row_t      rd_row_i,
  output logic                   wr_en_o,
  output lu_pkg::row_addr_t      wr_addr_o,
  output lu_pkg::row_t           wr_row_o,
  output logic                   result_valid_o,
  input  wire logic              result_ready_i,
  output lu_pkg::row_addr_t      result_k_o,
  output lu_pkg::row_t           l_col_o,
  output lu_pkg::row_t           u_row_o
);
  localparam int EW = 2 * `LU_DW;
  localparam lu_pkg::row_addr_t LAST = lu_pkg::row_addr_t'(`LU_N - 1);
  localparam cplx_pkg::cplx_t ONE = cplx_pkg::cplx_t'(1) << `LU_FRAC;

  lu_pkg::lu_state_t state;
  lu_pkg::row_addr_t k, iss_cnt, ret_cnt, n_lower, pend_addr;
  logic              row_pend, row_take, piv_sent;
  lu_pkg::row_t      u_row, l_col;
  cplx_pkg::cplx_t   recip_q;

  logic              pivot_valid, pivot_ready, recip_valid, recip_ready;
  cplx_pkg::cplx_t   pivot, recip;

  logic              upd_in_valid, upd_in_ready, upd_out_valid, upd_out_ready;
  cplx_pkg::cplx_t   upd_l;
  lu_pkg::row_t      upd_row;
  lu_pkg::row_addr_t upd_idx, upd_k;

  assign n_lower   = LAST - k;  // rows below the pivot
  assign pend_addr = k + iss_cnt;  // row sitting on rd_row_i

  assign busy_o         = state != lu_pkg::IDLE;
  assign result_valid_o = state == lu_pkg::EMIT;
  assign result_k_o     = k;
  assign l_col_o        = l_col;
  assign u_row_o        = u_row;

  assign pivot       = u_row[k*EW +: EW];
  assign pivot_valid = (state == lu_pkg::RECIP) && !piv_sent;
  assign recip_ready = state == lu_pkg::RECIP;

  assign upd_in_valid  = (state == lu_pkg::UPDATE) && row_pend;
  assign upd_out_ready = state == lu_pkg::UPDATE;
  assign row_take      = (state == lu_pkg::PIVOT) || ((state == lu_pkg::UPDATE) && upd_in_ready);

  assign wr_en_o   = upd_out_valid && upd_out_ready;
  assign wr_addr_o = upd_idx;
  assign wr_row_o  = upd_row;

  always_comb begin
    rd_en_o   = 1'b0;
    rd_addr_o = k;
    if (state == lu_pkg::PIVOT) begin
      rd_en_o = !row_pend;
    end else if (state == lu_pkg::UPDATE) begin
      rd_en_o   = (iss_cnt != n_lower) && (!row_pend || upd_in_ready);
      rd_addr_o = k + iss_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state    <= lu_pkg::IDLE;
      k        <= '0;
      iss_cnt  <= '0;
      ret_cnt  <= '0;
      row_pend <= 1'b0;
      piv_sent <= 1'b0;
    end else begin
      row_pend <= rd_en_o || (row_pend && !row_take);  // read data lands next cycle
      case (state)
        lu_pkg::IDLE: begin
          if (start_i) begin
            k     <= '0;
            state <= lu_pkg::PIVOT;
          end
        end
        lu_pkg::PIVOT: begin
          if (row_pend) begin
            piv_sent <= 1'b0;
            state    <= (k == LAST) ? lu_pkg::EMIT : lu_pkg::RECIP;
          end
        end
        lu_pkg::RECIP: begin
          if (pivot_valid && pivot_ready) piv_sent <= 1'b1;
          if (recip_valid) begin
            iss_cnt <= '0;
            ret_cnt <= '0;
            state   <= lu_pkg::UPDATE;
          end
        end
        lu_pkg::UPDATE: begin
          if (rd_en_o) iss_cnt <= iss_cnt + 1'b1;
          if (wr_en_o) begin
            ret_cnt <= ret_cnt + 1'b1;
            if (ret_cnt == n_lower - 1'b1) state <= lu_pkg::EMIT;
          end
        end
        lu_pkg::EMIT: begin
          if (result_ready_i) begin
            if (k == LAST) begin
              state <= lu_pkg::DONE;
            end else begin
              k     <= k + 1'b1;
              state <= lu_pkg::PIVOT;
            end
          end
        end
        lu_pkg::DONE: state <= lu_pkg::IDLE;
        default: state <= lu_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == lu_pkg::PIVOT) && row_pend) begin
      for (int i = 0; i < `LU_N; i++) begin
        u_row[i*EW +: EW] <= (i < k) ? '0 : rd_row_i[i*EW +: EW];
        l_col[i*EW +: EW] <= (i == k) ? ONE : '0;
      end
    end
    if ((state == lu_pkg::RECIP) && recip_valid) begin
      recip_q <= recip;
    end
    if (wr_en_o) begin
      l_col[upd_idx*EW +: EW] <= upd_l;
    end
  end

  cplx_recip u_recip (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (pivot_valid),
    .in_ready_o  (pivot_ready),
    .pivot_i     (pivot),
    .out_valid_o (recip_valid),
    .out_ready_i (recip_ready),
    .recip_o     (recip)
  );

  lu_row_update u_update (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (upd_in_valid),
    .in_ready_o  (upd_in_ready),
    .lower_row_i (rd_row_i),
    .pivot_row_i (u_row),
    .recip_i     (recip_q),
    .idx_i       (pend_addr),
    .k_i         (k),
    .out_valid_o (upd_out_valid),
    .out_ready_i (upd_out_ready),
    .l_o         (upd_l),
    .row_o       (upd_row),
    .idx_o       (upd_idx),
    .k_o         (upd_k)
  );

  // write-backs only hit rows below the current pivot
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state == lu_pkg::UPDATE) && wr_en_o) |-> ((wr_addr_o > k) && (upd_k == k)));

endmodule

`default_nettype wire

/* lu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module lu_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              load_we_i,
  input  wire lu_pkg::row_addr_t load_addr_i,
  input  wire lu_pkg::row_t      load_row_i,
  input  wire logic              start_i,
  output logic                   busy_o,
  output logic                   result_valid_o,
  input  wire logic              result_ready_i,
  output lu_pkg::row_addr_t      result_k_o,
  output lu_pkg::row_t           l_col_o,
  output lu_pkg::row_t           u_row_o
);
  logic              rd_en, wr_en;
  lu_pkg::row_addr_t rd_addr, wr_addr;
  lu_pkg::row_t      rd_row, wr_row;

  lu_row_mem u_mem (
    .clk_i       (clk_i),
    .host_we_i   (load_we_i),
    .host_addr_i (load_addr_i),
    .host_row_i  (load_row_i),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_row_o    (rd_row),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_row_i    (wr_row)
  );

  lu_engine u_engine (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .busy_o         (busy_o),
    .rd_en_o        (rd_en),
    .rd_addr_o      (rd_addr),
    .rd_row_i       (rd_row),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_row_o       (wr_row),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_k_o     (result_k_o),
    .l_col_o        (l_col_o),
    .u_row_o        (u_row_o)
  );

endmodule

`default_nettype wire

/* tb_lu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lu_defs.svh"

module tb_lu_top;
  localparam int N       = `LU_N;
  localparam int DW      = `LU_DW;
  localparam int FRAC    = `LU_FRAC;
  localparam int EW      = 2 * `LU_DW;
  localparam int TIMEOUT = 5000;  // cycles per run

  logic              clk, rst_n, load_we, start, busy, res_valid;
  logic              res_ready = 1'b0;
  logic              bp_on = 1'b0;
  lu_pkg::row_addr_t load_addr, res_k;
  lu_pkg::row_t      load_row, l_col, u_row;

  lu_pkg::row_t mat [N];
  lu_pkg::row_t exp_l [N];
  lu_pkg::row_t exp_u [N];
  int got_total = 0;
  int test_base = 0;
  int cmp_idx;
  int cmp_errors = 0;
  int seq_errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  bit aborted = 1'b0;  // a run hung, later tests are skipped

  lu_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .load_we_i      (load_we),
    .load_addr_i    (load_addr),
    .load_row_i     (load_row),
    .start_i        (start),
    .busy_o         (busy),
    .result_valid_o (res_valid),
    .result_ready_i (res_ready),
    .result_k_o     (res_k),
    .l_col_o        (l_col),
    .u_row_o        (u_row)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic cplx_pkg::cplx_t mk_cplx(int re, int im);
    return {cplx_pkg::comp_t'(im), cplx_pkg::comp_t'(re)};
  endfunction

  function automatic longint re_of(cplx_pkg::cplx_t c);
    return longint'($signed(c[DW-1:0]));
  endfunction

  function automatic longint im_of(cplx_pkg::cplx_t c);
    return longint'($signed(c[EW-1:DW]));
  endfunction

  function automatic cplx_pkg::cplx_t mul_model(cplx_pkg::cplx_t a, cplx_pkg::cplx_t b);
    longint re, im;
    re = (re_of(a) * re_of(b) - im_of(a) * im_of(b)) >>> FRAC;
    im = (re_of(a) * im_of(b) + im_of(a) * re_of(b)) >>> FRAC;
    return mk_cplx(int'(re), int'(im));
  endfunction

  function automatic cplx_pkg::cplx_t sub_wrap(cplx_pkg::cplx_t a, cplx_pkg::cplx_t b);
    return mk_cplx(int'(re_of(a) - re_of(b)), int'(im_of(a) - im_of(b)));
  endfunction

  // conj(p) * 2^(2*frac) / |p|^2, truncated toward zero
  function automatic cplx_pkg::cplx_t recip_model(cplx_pkg::cplx_t p);
    longint pr, pi, mag, qr, qi;
    pr  = re_of(p);
    pi  = im_of(p);
    mag = pr * pr + pi * pi;
    qr  = ((pr < 0 ? -pr : pr) << (2 * FRAC)) / mag;
    qi  = ((pi < 0 ? -pi : pi) << (2 * FRAC)) / mag;
    if (pr < 0) qr = -qr;
    if (pi > 0) qi = -qi;  // conjugate
    return mk_cplx(int'(qr), int'(qi));
  endfunction

  // fills exp_l and exp_u from mat
  function automatic void lu_ref();
    lu_pkg::row_t    w [N];
    cplx_pkg::cplx_t rc, l;
    for (int i = 0; i < N; i++) w[i] = mat[i];
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        exp_u[k][j*EW +: EW] = (j < k) ? '0 : w[k][j*EW +: EW];
        exp_l[k][j*EW +: EW] = (j == k) ? mk_cplx(1 << FRAC, 0) : '0;
      end
      if (k < N - 1) begin
        rc = recip_model(w[k][k*EW +: EW]);
        for (int i = k + 1; i < N; i++) begin
          l = mul_model(w[i][k*EW +: EW], rc);
          exp_l[k][i*EW +: EW] = l;
          for (int j = 0; j < N; j++) begin
            w[i][j*EW +: EW] = sub_wrap(w[i][j*EW +: EW], mul_model(l, exp_u[k][j*EW +: EW]));
          end
        end
      end
    end
  endfunction

  function automatic int rand_in(int lo, int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  // diagonal at least four times the off-diagonal row sum
  task automatic gen_dominant();
    int sgn;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        if (i == j) begin
          sgn = ($urandom_range(1) == 1) ? -1 : 1;
          mat[i][j*EW +: EW] = mk_cplx(sgn * rand_in(3200, 5200), rand_in(-500, 500));
        end else begin
          mat[i][j*EW +: EW] = mk_cplx(rand_in(-128, 128), rand_in(-128, 128));
        end
      end
    end
  endtask

  task automatic set_signed_pivots();
    gen_dominant();
    for (int i = 0; i < N; i++) begin
      case (i % 4)
        0: mat[i][i*EW +: EW] = mk_cplx(0, 3500);  // pure imaginary
        1: mat[i][i*EW +: EW] = mk_cplx(-3300, 0);
        2: mat[i][i*EW +: EW] = mk_cplx(0, -4000);
        default: mat[i][i*EW +: EW] = mk_cplx(-2900, -1200);
      endcase
    end
  endtask

  task automatic set_identity();
    for (int i = 0; i < N; i++) begin
      mat[i] = '0;
      mat[i][i*EW +: EW] = mk_cplx(1 << FRAC, 0);
    end
  endtask

  task automatic load_matrix();
    for (int r = 0; r < N; r++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= lu_pkg::row_addr_t'(r);
      load_row  <= mat[r];
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  // reset while the engine is in the middle of a pivot
  task automatic reset_during_run();
    int cyc;
    int errs_before;
    if (!aborted) begin
      errs_before = cmp_errors + seq_errors;
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      cyc = 0;
      while (!busy && (cyc < TIMEOUT)) begin
        @(negedge clk);
        cyc++;
      end
      if (!busy) begin
        seq_errors++;
        $display("busy_o did not rise before the reset in the middle of a run");
      end
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (busy || res_valid) begin
        seq_errors++;
        $display("busy_o or result_valid_o is high right after reset");
      end
      if (cmp_errors + seq_errors == errs_before) begin
        n_pass++;
        $display("test reset during a run: ok");
      end else begin
        n_fail++;
        $display("test reset during a run: FAILED");
      end
    end
  endtask

  task automatic run_case(input string name, input bit bp);
    int cyc;
    int errs_before;
    if (!aborted) begin
      errs_before = cmp_errors + seq_errors;
      lu_ref();
      @(negedge clk);
      bp_on = bp;
      load_matrix();
      test_base = got_total;
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      if (!busy) begin
        seq_errors++;
        $display("busy_o did not rise after start in test %s", name);
      end
      cyc = 0;
      while ((got_total - test_base < N) && (cyc < TIMEOUT)) begin
        @(posedge clk);
        cyc++;
      end
      if (got_total - test_base < N) begin
        aborted = 1'b1;
        n_fail++;
        $display("timed out in test %s with %0d of %0d results", name,
                 got_total - test_base, N);
      end else begin
        cyc = 0;
        while (busy && (cyc < 4)) begin
          @(negedge clk);
          cyc++;
        end
        if (busy) begin
          aborted = 1'b1;
          n_fail++;
          $display("busy_o stayed high after the last result in test %s", name);
        end else begin
          repeat (4) @(posedge clk);  // room for a stray extra result
          if (cmp_errors + seq_errors == errs_before) begin
            n_pass++;
            $display("test %s: ok", name);
          end else begin
            n_fail++;
            $display("test %s: FAILED", name);
          end
        end
      end
    end
  endtask

  // random back-pressure on the result stream
  always @(posedge clk) begin
    res_ready <= bp_on ? 1'($urandom_range(1)) : 1'b1;
  end

  always @(posedge clk) begin
    if (rst_n && res_valid && res_ready) begin
      cmp_idx = got_total - test_base;
      if (cmp_idx >= N) begin
        cmp_errors++;
        $display("extra result with k=%0d after %0d results", res_k, N);
      end else begin
        if (int'(res_k) != cmp_idx) begin
          cmp_errors++;
          $display("MISMATCH at %0t: result_k got %0d expected %0d", $time, res_k, cmp_idx);
        end
        if (l_col != exp_l[cmp_idx]) begin
          cmp_errors++;
          $display("MISMATCH at %0t: k=%0d l_col got %h expected %h",
                   $time, cmp_idx, l_col, exp_l[cmp_idx]);
        end
        if (u_row != exp_u[cmp_idx]) begin
          cmp_errors++;
          $display("MISMATCH at %0t: k=%0d u_row got %h expected %h",
                   $time, cmp_idx, u_row, exp_u[cmp_idx]);
        end
      end
      got_total++;
    end
  end

  initial begin
    void'($urandom(32'h9fd9));
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_row  = '0;
    start     = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (busy || res_valid) begin
      seq_errors++;
      $display("busy_o or result_valid_o is high after the first reset");
    end
    set_identity();
    run_case("identity", 1'b0);
    gen_dominant();
    run_case("random dominant", 1'b0);
    run_case("back-pressure", 1'b1);  // same matrix again
    set_signed_pivots();
    run_case("imaginary and negative pivots", 1'b0);
    reset_during_run();
    gen_dominant();
    run_case("run after reset", 1'b0);
    gen_dominant();
    run_case("second start", 1'b1);
    $display("tests passed %0d, failed %0d, failed checks %0d",
             n_pass, n_fail, cmp_errors + seq_errors);
    if (aborted || (cmp_errors + seq_errors != 0)) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
cplx_pkg.sv
lu_pkg.sv
cplx_recip.sv
lu_row_update.sv
lu_row_mem.sv
lu_engine.sv
lu_top.sv
tb_lu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lu_top -f build.f -o sim_lu \
  && ./obj_dir/sim_lu 2>&1 | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -q "RESULT: FAIL" sim.log \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }
